// File: Bender.yml
package:
  name: lsu_dcache_port

sources:
  - rtl/lsu_dcache_pkg.sv
  - rtl/dcache_req_arbiter.sv
  - rtl/dcache_ans_router.sv
  - rtl/lsu_dcache_port.sv
  - target: simulation
    files:
      - sim/tb_lsu_dcache_port.sv

// File: list.f
rtl/lsu_dcache_pkg.sv
rtl/dcache_req_arbiter.sv
rtl/dcache_ans_router.sv
rtl/lsu_dcache_port.sv
sim/tb_lsu_dcache_port.sv

// File: rtl/dcache_ans_router.sv
// Routes data-cache answers and wake-ups back to the load buffer or the
// store buffer, chosen by the answer's was-store flag. The answer payload
// goes to both buffers; only the valid strobes are steered. The cache's
// ready comes from the buffer being answered. No state, zero latency;
// the clock input only samples the assertions.

`timescale 1ns/10ps

module dcache_ans_router
    import lsu_dcache_pkg::*;
(
    input  logic            clk_i,

    // From the cache
    input  l1dc_lsq_ans_t   dcache_ans_i,
    input  l1dc_lsq_wup_t   dcache_wup_i,
    output logic            dcache_ans_ready_o,

    // Ready from the buffers
    input  logic            lb_ans_ready_i,
    input  logic            sb_ans_ready_i,

    // Strobes to the buffers
    output logic            lb_ans_valid_o,
    output logic            sb_ans_valid_o,
    output logic            lb_wup_valid_o,
    output logic            sb_wup_valid_o,

    // Shared payload
    output lsb_dcache_ans_t ans_o,
    output xlen_t           wup_addr_o
);

    // Handshake decoder
    always_comb begin
        if (dcache_ans_i.was_store) begin
            lb_ans_valid_o     = 1'b0;
            lb_wup_valid_o     = 1'b0;
            sb_ans_valid_o     = dcache_ans_i.valid;
            sb_wup_valid_o     = dcache_wup_i.valid;
            dcache_ans_ready_o = sb_ans_ready_i;
        end else begin
            lb_ans_valid_o     = dcache_ans_i.valid;
            lb_wup_valid_o     = dcache_wup_i.valid;
            sb_ans_valid_o     = 1'b0;
            sb_wup_valid_o     = 1'b0;
            dcache_ans_ready_o = lb_ans_ready_i;
        end
    end

    // A wake-up carries only a line address so the answer fields are cleared
    always_comb begin
        if (dcache_wup_i.valid) begin
            ans_o      = '0;
            wup_addr_o = dcache_wup_i.line_addr;
        end else begin
            ans_o.idx   = dcache_ans_i.lsq_addr;
            ans_o.value = dcache_ans_i.data;
            wup_addr_o  = '0;
        end
    end

    // Never strobe both buffers in the same cycle
    a_side_exclusive: assert property (
        @(posedge clk_i)
        !((lb_ans_valid_o || lb_wup_valid_o) && (sb_ans_valid_o || sb_wup_valid_o))
    ) else $error("answer routed to both load and store side");

endmodule

// File: rtl/dcache_req_arbiter.sv
// Fair two-way arbiter between the load buffer and the store buffer
// for the data-cache request port, plus the request multiplexer.
// On a tie the side not served last wins. The selected request is
// flattened into cache fields: loads always read a doubleword, stores
// get a write width from their store type. Purely combinational from
// valid to request; only the last-served record is registered.

`timescale 1ns/10ps

module dcache_req_arbiter
    import lsu_dcache_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_i,

    // Load buffer
    input  logic           lb_valid_i,
    input  lb_dcache_req_t lb_req_i,
    output logic           lb_ready_o,

    // Store buffer
    input  logic           sb_valid_i,
    input  sb_dcache_req_t sb_req_i,
    output logic           sb_ready_o,

    // Cache side
    input  logic           dcache_ready_i,
    output logic           req_valid_o,
    output req_type_t      req_type_o,
    output xlen_t          req_paddr_o,
    output xlen_t          req_data_o,
    output store_width_t   req_width_o,
    output buff_idx_t      req_idx_o
);

    // Side that got the last transfer
    req_type_t    last_served_q;
    logic         grant_lb;
    logic         transfer;
    store_width_t st_width;

    // Load wins when alone, or on a tie when the store went last
    assign grant_lb = lb_valid_i & (~sb_valid_i | (last_served_q == STORE));

    assign req_valid_o = lb_valid_i | sb_valid_i;
    assign transfer    = req_valid_o & dcache_ready_i;

    assign lb_ready_o = grant_lb & dcache_ready_i;
    assign sb_ready_o = ~grant_lb & sb_valid_i & dcache_ready_i;

    // Starts as STORE so the first tie goes to the load buffer
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            last_served_q <= STORE;
        end else if (transfer) begin
            last_served_q <= grant_lb ? LOAD : STORE;
        end
    end

    // Signed and unsigned variants share a store width
    always_comb begin
        case (sb_req_i.sttype)
            LS_BYTE, LS_BYTE_U:         st_width = B;
            LS_HALFWORD, LS_HALFWORD_U: st_width = HW;
            LS_WORD, LS_WORD_U:         st_width = W;
            LS_DOUBLEWORD:              st_width = DW;
            default:                    st_width = DW;
        endcase
    end

    // Request mux with indices zero-extended to the cache index width
    always_comb begin
        if (grant_lb) begin
            req_type_o  = LOAD;
            req_paddr_o = lb_req_i.paddr;
            req_data_o  = '0;
            req_width_o = DW;
            req_idx_o   = buff_idx_t'(lb_req_i.idx);
        end else begin
            req_type_o  = STORE;
            req_paddr_o = sb_req_i.paddr;
            req_data_o  = sb_req_i.value;
            req_width_o = st_width;
            req_idx_o   = buff_idx_t'(sb_req_i.idx);
        end
    end

    // Only one buffer may see its request accepted in a cycle
    a_ready_exclusive: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(lb_ready_o && sb_ready_o)
    ) else $error("load and store ready asserted together");

    // A buffer is never told ready without offering a request
    a_lb_ready_valid: assert property (
        @(posedge clk_i) disable iff (rst_i)
        lb_ready_o |-> lb_valid_i
    ) else $error("lb_ready_o high without lb_valid_i");

    a_sb_ready_valid: assert property (
        @(posedge clk_i) disable iff (rst_i)
        sb_ready_o |-> sb_valid_i
    ) else $error("sb_ready_o high without sb_valid_i");

endmodule

// File: rtl/lsu_dcache_pkg.sv
// Shared definitions for the load/store unit data-cache channel.
// Holds the widths, buffer index types, load/store type encodings and
// the request/answer structs exchanged with the L1 data cache.
// Modules take what they need through a wildcard import in their header.

package lsu_dcache_pkg;

    // Data and address width
    localparam int XLEN = 64;

    // Buffer index widths
    localparam int LDBUFF_IDX_LEN = 3;
    localparam int STBUFF_IDX_LEN = 2;

    // Cache side index is wide enough for either buffer
    localparam int BUFF_IDX_LEN = (LDBUFF_IDX_LEN > STBUFF_IDX_LEN) ?
                                  LDBUFF_IDX_LEN : STBUFF_IDX_LEN;

    typedef logic [XLEN-1:0]           xlen_t;
    typedef logic [LDBUFF_IDX_LEN-1:0] ldbuff_idx_t;
    typedef logic [STBUFF_IDX_LEN-1:0] stbuff_idx_t;
    typedef logic [BUFF_IDX_LEN-1:0]   buff_idx_t;

    // Load/store access types where the unsigned variants only matter for loads
    typedef enum logic [2:0] {
        LS_BYTE       = 3'd0,
        LS_BYTE_U     = 3'd1,
        LS_HALFWORD   = 3'd2,
        LS_HALFWORD_U = 3'd3,
        LS_WORD       = 3'd4,
        LS_WORD_U     = 3'd5,
        LS_DOUBLEWORD = 3'd6
    } ldst_type_t;

    // Width of a cache write
    typedef enum logic [1:0] {
        B  = 2'd0,
        HW = 2'd1,
        W  = 2'd2,
        DW = 2'd3
    } store_width_t;

    typedef enum logic {
        LOAD  = 1'b0,
        STORE = 1'b1
    } req_type_t;

    // Load buffer request
    typedef struct packed {
        xlen_t       paddr;
        ldbuff_idx_t idx;
    } lb_dcache_req_t;

    // Store buffer request
    typedef struct packed {
        xlen_t       paddr;
        xlen_t       value;
        stbuff_idx_t idx;
        ldst_type_t  sttype;
    } sb_dcache_req_t;

    // Request to the L1 data cache
    typedef struct packed {
        logic         valid;
        req_type_t    req_type;
        xlen_t        paddr;
        xlen_t        data;
        store_width_t store_width;
        buff_idx_t    lsq_addr;
    } lsq_l1dc_req_t;

    // Answer from the L1 data cache
    typedef struct packed {
        logic      valid;
        logic      was_store;
        buff_idx_t lsq_addr;
        xlen_t     data;
    } l1dc_lsq_ans_t;

    // Wake-up from the L1 data cache after a line refill
    typedef struct packed {
        logic  valid;
        xlen_t line_addr;
    } l1dc_lsq_wup_t;

    // Answer payload sent to both buffers
    typedef struct packed {
        buff_idx_t idx;
        xlen_t     value;
    } lsb_dcache_ans_t;

endpackage

// File: rtl/lsu_dcache_port.sv
// Data-cache channel of the load/store unit.
// The request arbiter picks between the load and store buffers while the
// answer router steers cache answers back to them. This level only packs
// the arbiter's fields into the cache request struct and hands the cache
// answer structs to the router.

`timescale 1ns/10ps

module lsu_dcache_port
    import lsu_dcache_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_i,

    // Requests from the buffers
    input  logic            lb_valid_i,
    input  lb_dcache_req_t  lb_req_i,
    input  logic            sb_valid_i,
    input  sb_dcache_req_t  sb_req_i,
    output logic            lb_ready_o,
    output logic            sb_ready_o,

    // Answers to the buffers
    input  logic            lb_ans_ready_i,
    input  logic            sb_ans_ready_i,
    output logic            lb_ans_valid_o,
    output logic            sb_ans_valid_o,
    output logic            lb_wup_valid_o,
    output logic            sb_wup_valid_o,
    output lsb_dcache_ans_t ans_o,
    output xlen_t           wup_addr_o,

    // L1 data cache
    output lsq_l1dc_req_t   dcache_req_o,
    input  logic            dcache_ready_i,
    input  l1dc_lsq_ans_t   dcache_ans_i,
    input  l1dc_lsq_wup_t   dcache_wup_i,
    output logic            dcache_ans_ready_o
);

    logic         req_valid;
    req_type_t    req_type;
    xlen_t        req_paddr;
    xlen_t        req_data;
    store_width_t req_width;
    buff_idx_t    req_idx;

    dcache_req_arbiter u_req_arbiter (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .lb_valid_i     (lb_valid_i),
        .lb_req_i       (lb_req_i),
        .lb_ready_o     (lb_ready_o),
        .sb_valid_i     (sb_valid_i),
        .sb_req_i       (sb_req_i),
        .sb_ready_o     (sb_ready_o),
        .dcache_ready_i (dcache_ready_i),
        .req_valid_o    (req_valid),
        .req_type_o     (req_type),
        .req_paddr_o    (req_paddr),
        .req_data_o     (req_data),
        .req_width_o    (req_width),
        .req_idx_o      (req_idx)
    );

    // Cache request struct
    assign dcache_req_o.valid       = req_valid;
    assign dcache_req_o.req_type    = req_type;
    assign dcache_req_o.paddr       = req_paddr;
    assign dcache_req_o.data        = req_data;
    assign dcache_req_o.store_width = req_width;
    assign dcache_req_o.lsq_addr    = req_idx;

    dcache_ans_router u_ans_router (
        .clk_i              (clk_i),
        .dcache_ans_i       (dcache_ans_i),
        .dcache_wup_i       (dcache_wup_i),
        .dcache_ans_ready_o (dcache_ans_ready_o),
        .lb_ans_ready_i     (lb_ans_ready_i),
        .sb_ans_ready_i     (sb_ans_ready_i),
        .lb_ans_valid_o     (lb_ans_valid_o),
        .sb_ans_valid_o     (sb_ans_valid_o),
        .lb_wup_valid_o     (lb_wup_valid_o),
        .sb_wup_valid_o     (sb_wup_valid_o),
        .ans_o              (ans_o),
        .wup_addr_o         (wup_addr_o)
    );

endmodule

// File: sim/tb_lsu_dcache_port.sv
// Testbench for the load/store unit data-cache channel.
// A table of rows is applied one row per clock cycle. Each row sets the
// request valids, the cache ready, the store type and the answer fields.
// A last-served model predicts the fair grant, and every output is
// compared just before the next rising edge.

`timescale 1ns/10ps

module tb_lsu_dcache_port
    import lsu_dcache_pkg::*;
;

    localparam int IDLE_TIMEOUT = 10;

    // One stimulus row
    typedef struct packed {
        logic       lb_v;
        logic       sb_v;
        logic       rdy;
        ldst_type_t sttype;
        logic       ans_v;
        logic       was_st;
        logic       wup_v;
        logic       lb_ar;
        logic       sb_ar;
    } row_t;

    logic            clk;
    logic            rst;
    logic            lb_valid;
    lb_dcache_req_t  lb_req;
    logic            sb_valid;
    sb_dcache_req_t  sb_req;
    logic            lb_ready;
    logic            sb_ready;
    logic            lb_ans_ready;
    logic            sb_ans_ready;
    logic            lb_ans_valid;
    logic            sb_ans_valid;
    logic            lb_wup_valid;
    logic            sb_wup_valid;
    lsb_dcache_ans_t ans;
    xlen_t           wup_addr;
    lsq_l1dc_req_t   dcache_req;
    logic            dcache_ready;
    l1dc_lsq_ans_t   dcache_ans;
    l1dc_lsq_wup_t   dcache_wup;
    logic            dcache_ans_ready;

    row_t        rows[$];
    logic [15:0] lfsr;
    logic        last_store;
    int          n_checks;
    int          n_errors;

    lsu_dcache_port i_lsu_dcache_port (
        .clk_i              (clk),
        .rst_i              (rst),
        .lb_valid_i         (lb_valid),
        .lb_req_i           (lb_req),
        .sb_valid_i         (sb_valid),
        .sb_req_i           (sb_req),
        .lb_ready_o         (lb_ready),
        .sb_ready_o         (sb_ready),
        .lb_ans_ready_i     (lb_ans_ready),
        .sb_ans_ready_i     (sb_ans_ready),
        .lb_ans_valid_o     (lb_ans_valid),
        .sb_ans_valid_o     (sb_ans_valid),
        .lb_wup_valid_o     (lb_wup_valid),
        .sb_wup_valid_o     (sb_wup_valid),
        .ans_o              (ans),
        .wup_addr_o         (wup_addr),
        .dcache_req_o       (dcache_req),
        .dcache_ready_i     (dcache_ready),
        .dcache_ans_i       (dcache_ans),
        .dcache_wup_i       (dcache_wup),
        .dcache_ans_ready_o (dcache_ans_ready)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Fibonacci LFSR with taps at 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output xlen_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[XLEN-2:0], lfsr[0]};
        end
    endtask

    // Write width expected for each store type
    function automatic store_width_t width_of(input ldst_type_t t);
        if (t == LS_BYTE || t == LS_BYTE_U)
            return B;
        if (t == LS_HALFWORD || t == LS_HALFWORD_U)
            return HW;
        if (t == LS_WORD || t == LS_WORD_U)
            return W;
        return DW;
    endfunction

    task automatic check_value(input string name, input xlen_t exp, input xlen_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERROR at %0t: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    task automatic add_row(input logic lb_v, input logic sb_v, input logic rdy,
                           input ldst_type_t sttype, input logic ans_v,
                           input logic was_st, input logic wup_v,
                           input logic lb_ar, input logic sb_ar);
        row_t r;
        r = '{lb_v, sb_v, rdy, sttype, ans_v, was_st, wup_v, lb_ar, sb_ar};
        rows.push_back(r);
    endtask

    task automatic apply_row(input row_t r);
        xlen_t v;
        lb_valid     = r.lb_v;
        sb_valid     = r.sb_v;
        dcache_ready = r.rdy;
        random_bits(XLEN, v);
        lb_req.paddr = v;
        random_bits(LDBUFF_IDX_LEN, v);
        lb_req.idx   = ldbuff_idx_t'(v);
        random_bits(XLEN, v);
        sb_req.paddr = v;
        random_bits(XLEN, v);
        sb_req.value = v;
        random_bits(STBUFF_IDX_LEN, v);
        sb_req.idx    = stbuff_idx_t'(v);
        sb_req.sttype = r.sttype;
        dcache_ans.valid     = r.ans_v;
        dcache_ans.was_store = r.was_st;
        random_bits(BUFF_IDX_LEN, v);
        dcache_ans.lsq_addr  = buff_idx_t'(v);
        random_bits(XLEN, v);
        dcache_ans.data      = v;
        dcache_wup.valid     = r.wup_v;
        random_bits(XLEN, v);
        dcache_wup.line_addr = v;
        lb_ans_ready = r.lb_ar;
        sb_ans_ready = r.sb_ar;
    endtask

    task automatic check_row(input row_t r);
        logic grant_lb;
        logic grant_sb;
        logic any_valid;
        // On a tie the side not served last wins
        if (r.lb_v && r.sb_v) begin
            grant_lb = last_store;
            grant_sb = ~last_store;
        end else begin
            grant_lb = r.lb_v;
            grant_sb = r.sb_v;
        end
        any_valid = r.lb_v | r.sb_v;
        check_value("dcache_req_o.valid", any_valid, dcache_req.valid);
        check_value("lb_ready_o", grant_lb & r.rdy, lb_ready);
        check_value("sb_ready_o", grant_sb & r.rdy, sb_ready);
        if (grant_lb) begin
            check_value("dcache_req_o.req_type", LOAD, dcache_req.req_type);
            check_value("dcache_req_o.paddr", lb_req.paddr, dcache_req.paddr);
            check_value("dcache_req_o.data", '0, dcache_req.data);
            check_value("dcache_req_o.store_width", DW, dcache_req.store_width);
            check_value("dcache_req_o.lsq_addr", lb_req.idx, dcache_req.lsq_addr);
        end else if (grant_sb) begin
            check_value("dcache_req_o.req_type", STORE, dcache_req.req_type);
            check_value("dcache_req_o.paddr", sb_req.paddr, dcache_req.paddr);
            check_value("dcache_req_o.data", sb_req.value, dcache_req.data);
            check_value("dcache_req_o.store_width", width_of(r.sttype),
                        dcache_req.store_width);
            check_value("dcache_req_o.lsq_addr", sb_req.idx, dcache_req.lsq_addr);
        end
        check_value("lb_ans_valid_o", r.ans_v & ~r.was_st, lb_ans_valid);
        check_value("sb_ans_valid_o", r.ans_v & r.was_st, sb_ans_valid);
        check_value("lb_wup_valid_o", r.wup_v & ~r.was_st, lb_wup_valid);
        check_value("sb_wup_valid_o", r.wup_v & r.was_st, sb_wup_valid);
        check_value("dcache_ans_ready_o", r.was_st ? r.sb_ar : r.lb_ar, dcache_ans_ready);
        check_value("ans_o.idx", r.wup_v ? '0 : dcache_ans.lsq_addr, ans.idx);
        check_value("ans_o.value", r.wup_v ? '0 : dcache_ans.data, ans.value);
        check_value("wup_addr_o", r.wup_v ? dcache_wup.line_addr : '0, wup_addr);
        // Record moves only on a transfer
        if (any_valid && r.rdy)
            last_store = grant_sb;
    endtask

    // Request port must settle to idle once reset is released
    task automatic wait_idle(output logic timed_out);
        int cycles;
        cycles = 0;
        while ((dcache_req.valid !== 1'b0 || lb_ready !== 1'b0 || sb_ready !== 1'b0)
               && cycles < IDLE_TIMEOUT) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        timed_out = (dcache_req.valid !== 1'b0 || lb_ready !== 1'b0 || sb_ready !== 1'b0);
        if (timed_out) begin
            n_errors++;
            $display("Timeout: request port did not go idle after reset");
        end
    endtask

    initial begin
        logic timed_out;
        rst          = 1'b1;
        lb_valid     = 1'b0;
        lb_req       = '0;
        sb_valid     = 1'b0;
        sb_req       = '0;
        dcache_ready = 1'b0;
        dcache_ans   = '0;
        dcache_wup   = '0;
        lb_ans_ready = 1'b0;
        sb_ans_ready = 1'b0;
        lfsr         = 16'd84;
        last_store   = 1'b1;
        n_checks     = 0;
        n_errors     = 0;

        // lb_v sb_v rdy sttype ans_v was_st wup_v lb_ar sb_ar
        add_row(0, 0, 1, LS_BYTE,       0, 0, 0, 0, 0);
        add_row(0, 0, 0, LS_BYTE,       0, 0, 0, 1, 1);
        add_row(1, 0, 1, LS_WORD,       0, 0, 0, 0, 0);
        add_row(1, 0, 0, LS_WORD,       0, 0, 0, 0, 0);
        add_row(0, 1, 1, LS_BYTE,       0, 0, 0, 0, 0);
        add_row(0, 1, 1, LS_BYTE_U,     0, 0, 0, 0, 0);
        add_row(0, 1, 1, LS_HALFWORD,   0, 0, 0, 0, 0);
        add_row(0, 1, 1, LS_HALFWORD_U, 0, 0, 0, 0, 0);
        add_row(0, 1, 1, LS_WORD,       0, 0, 0, 0, 0);
        add_row(0, 1, 1, LS_WORD_U,     0, 0, 0, 0, 0);
        add_row(0, 1, 1, LS_DOUBLEWORD, 0, 0, 0, 0, 0);
        add_row(0, 1, 0, LS_WORD,       0, 0, 0, 0, 0);
        // Ties alternate, load first since the store went last
        add_row(1, 1, 1, LS_DOUBLEWORD, 0, 0, 0, 0, 0);
        add_row(1, 1, 1, LS_DOUBLEWORD, 0, 0, 0, 0, 0);
        add_row(1, 1, 1, LS_WORD,       0, 0, 0, 0, 0);
        add_row(1, 1, 1, LS_WORD,       0, 0, 0, 0, 0);
        add_row(1, 1, 0, LS_HALFWORD,   0, 0, 0, 0, 0);
        add_row(1, 1, 0, LS_HALFWORD,   0, 0, 0, 0, 0);
        add_row(1, 1, 0, LS_HALFWORD,   0, 0, 0, 0, 0);
        add_row(1, 1, 1, LS_BYTE,       0, 0, 0, 0, 0);
        add_row(1, 1, 1, LS_BYTE,       0, 0, 0, 0, 0);
        // Answers
        add_row(0, 0, 1, LS_BYTE,       1, 0, 0, 1, 0);
        add_row(0, 0, 1, LS_BYTE,       1, 0, 0, 0, 1);
        add_row(1, 0, 1, LS_BYTE,       1, 1, 0, 0, 1);
        add_row(0, 1, 1, LS_WORD,       1, 1, 0, 1, 0);
        // Wake-ups
        add_row(0, 0, 1, LS_BYTE,       0, 0, 1, 1, 0);
        add_row(1, 1, 1, LS_BYTE,       0, 1, 1, 0, 1);
        add_row(0, 0, 1, LS_BYTE,       1, 1, 1, 0, 1);
        add_row(0, 0, 0, LS_BYTE,       1, 0, 1, 1, 1);

        for (int c = 0; c < 3; c++)
            @(posedge clk);
        #2;
        rst = 1'b0;
        wait_idle(timed_out);

        if (!timed_out) begin
            for (int i = 0; i < rows.size(); i++) begin
                @(posedge clk);
                #2;
                apply_row(rows[i]);
                #36;
                check_row(rows[i]);
            end
        end

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
